//--- umi_switch_top.f
common/umi_pkg.sv
common/umi_if.sv
crossbar/umi_decode.sv
crossbar/umi_arbiter.sv
crossbar/umi_vmux.sv
crossbar/umi_crossbar.sv
verilog/umi_switch_top.sv
verif/umi_switch_tb.sv

//--- verif/umi_switch_tb.sv
// Directed testbench for the four-port UMI switch
// Runs routing, fixed and round-robin contention, back-pressure, mask and
// parallel path tests against umi_switch_top, stops at the first mismatch
`default_nettype none

module umi_switch_tb;

   import umi_pkg::*;

   localparam int max_cycles = 400;  // Well above the directed test length

   logic                    clk          = 1'b0;
   logic                    rst          = 1'b1;
   logic [umi_n-1:0]        in_valid     = '0;
   logic [umi_n*umi_cw-1:0] in_cmd       = '0;
   logic [umi_n*umi_aw-1:0] in_dst_addr  = '0;
   logic [umi_n*umi_aw-1:0] in_src_addr  = '0;
   logic [umi_n*umi_uw-1:0] in_payload   = '0;
   logic [umi_n-1:0]        in_ready;
   logic [umi_n-1:0]        out_valid;
   logic [umi_n*umi_cw-1:0] out_cmd;
   logic [umi_n*umi_aw-1:0] out_dst_addr;
   logic [umi_n*umi_aw-1:0] out_src_addr;
   logic [umi_n*umi_uw-1:0] out_payload;
   logic [umi_n-1:0]        out_ready    = '1;
   arb_mode_e               mode         = arb_fixed;
   logic [umi_n*umi_n-1:0]  mask         = '0;

   umi_cmd_t   exp_cmd [umi_n];  // Last message loaded per input
   umi_addr_t  exp_dst [umi_n];
   umi_addr_t  exp_src [umi_n];
   umi_data_t  exp_pld [umi_n];
   logic [31:0] lfsr   = 32'd84878;
   int          cycles = 0;

   umi_switch_top dut_i
   (
      .clk (clk), .rst (rst), .mode (mode), .mask (mask),
      .in_valid (in_valid), .in_cmd (in_cmd), .in_dst_addr (in_dst_addr),
      .in_src_addr (in_src_addr), .in_payload (in_payload), .in_ready (in_ready),
      .out_valid (out_valid), .out_cmd (out_cmd), .out_dst_addr (out_dst_addr),
      .out_src_addr (out_src_addr), .out_payload (out_payload), .out_ready (out_ready)
   );

   always #2 clk = ~clk;  // Period 4

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("Timeout: DUT did not finish within %0d cycles", max_cycles);
         $display("=== FAIL ===");
         $fatal(1);
      end
   end

   // ##############################
   // Helpers
   // ##############################

   // Galois form with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic rand_payload(output umi_data_t w);
      w = '0;
      for (int b = 0; b < umi_uw; b++)
      begin
         w    = {w[umi_uw-2:0], lfsr[0]};  // One step per bit
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic check_value(input string test, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected)
      else
      begin
         $display("FAIL %s: expected %h, actual %h", test, expected, actual);
         $display("=== FAIL ===");
         $fatal(1);
      end
   endtask

   // Next drive slot 1 unit after the rising edge
   task automatic step_cycle();
      @(posedge clk);
      #1;
   endtask

   // Put a fresh message on input p aimed at output o
   task automatic load_msg(input int p, input int o);
      umi_data_t pld;
      rand_payload(pld);
      exp_cmd[p] = umi_cmd_t'(32'hA500_0000 + p * 16 + o);
      exp_dst[p] = {umi_sel_w'(o), pld[umi_route_lsb-1:0]};  // Route in top bits
      exp_src[p] = umi_addr_t'(16'h0100 * p + 16'h0042);
      exp_pld[p] = pld;
      in_valid[p]                     = 1'b1;
      in_cmd[p*umi_cw +: umi_cw]      = exp_cmd[p];
      in_dst_addr[p*umi_aw +: umi_aw] = exp_dst[p];
      in_src_addr[p*umi_aw +: umi_aw] = exp_src[p];
      in_payload[p*umi_uw +: umi_uw]  = exp_pld[p];
   endtask

   // All four fields of output o against input p
   task automatic check_output(input string test, input int o, input int p);
      check_value({test, " cmd"}, exp_cmd[p], out_cmd[o*umi_cw +: umi_cw]);
      check_value({test, " dst_addr"}, exp_dst[p], out_dst_addr[o*umi_aw +: umi_aw]);
      check_value({test, " src_addr"}, exp_src[p], out_src_addr[o*umi_aw +: umi_aw]);
      check_value({test, " payload"}, exp_pld[p], out_payload[o*umi_uw +: umi_uw]);
   endtask

   // ##############################
   // Tests
   // ##############################

   task automatic reset_dut();
      rst      = 1'b1;
      in_valid = '0;
      repeat (4) @(posedge clk);
      #1 rst = 1'b0;
   endtask

   task automatic send_and_check(input int p, input int o);
      in_valid = '0;
      load_msg(p, o);
      @(negedge clk);
      check_value("routing out_valid", umi_n'(1) << o, out_valid);
      check_output("routing", o, p);
      check_value("routing in_ready", {umi_n{1'b1}}, in_ready);  // Idle inputs ready too
      step_cycle();  // Transfer on that edge
      in_valid = '0;
   endtask

   task automatic contend_fixed();
      int               order [3] = '{1, 2, 3};  // Lowest index first
      logic [umi_n-1:0] rdy   [3] = '{4'b0011, 4'b0111, 4'b1111};  // Idle and winner ready
      mode     = arb_fixed;
      in_valid = '0;
      for (int p = 1; p < umi_n; p++)
         load_msg(p, 0);
      for (int k = 0; k < 3; k++)
      begin
         @(negedge clk);
         check_value("fixed out_valid", 4'b0001, out_valid);
         check_output("fixed", 0, order[k]);
         check_value("fixed in_ready", rdy[k], in_ready);
         step_cycle();
         in_valid[order[k]] = 1'b0;  // Winner drops out
      end
      @(negedge clk);
      check_value("fixed drained", 4'b0000, out_valid);
      step_cycle();
   endtask

   task automatic contend_rr();
      int order [5] = '{0, 1, 2, 3, 0};  // Pointer one past each winner
      reset_dut();  // Pointers back at input 0
      mode = arb_rr;
      for (int p = 0; p < umi_n; p++)
         load_msg(p, 2);
      for (int k = 0; k < 5; k++)
      begin
         @(negedge clk);
         check_value("rr out_valid", 4'b0100, out_valid);
         check_output("rr", 2, order[k]);
         check_value("rr in_ready", umi_n'(1) << order[k], in_ready);
         step_cycle();
         load_msg(order[k], 2);  // Winner asks again
      end
      in_valid = '0;
      mode     = arb_fixed;
   endtask

   task automatic stall_check();
      in_valid     = '0;
      out_ready[3] = 1'b0;
      load_msg(1, 3);
      repeat (5)
      begin
         @(negedge clk);
         check_value("stall out_valid", 4'b1000, out_valid);
         check_output("stall", 3, 1);
         check_value("stall in_ready", 1'b0, in_ready[1]);
         step_cycle();
      end
      out_ready[3] = 1'b1;  // Transfer on the next edge
      @(negedge clk);
      check_output("stall release", 3, 1);
      check_value("stall release in_ready", 1'b1, in_ready[1]);
      step_cycle();
      in_valid = '0;
      @(negedge clk);
      check_value("stall done", 4'b0000, out_valid);
      step_cycle();
   endtask

   task automatic mask_check();
      in_valid                = '0;
      mask[1*umi_n + 2]       = 1'b1;  // Input 2 barred from output 1
      load_msg(2, 1);
      repeat (3)
      begin
         @(negedge clk);
         check_value("mask out_valid", 4'b0000, out_valid);
         check_value("mask in_ready", 1'b0, in_ready[2]);
         step_cycle();
      end
      load_msg(0, 1);
      @(negedge clk);
      check_value("mask other out_valid", 4'b0010, out_valid);
      check_output("mask other", 1, 0);
      check_value("mask other in_ready", 4'b1011, in_ready);
      step_cycle();
      in_valid = '0;
      mask     = '0;
   endtask

   task automatic parallel_check();
      in_valid = '0;
      for (int p = 0; p < umi_n; p++)
         load_msg(p, umi_n - 1 - p);  // Distinct output each
      @(negedge clk);
      check_value("parallel out_valid", {umi_n{1'b1}}, out_valid);
      check_value("parallel in_ready", {umi_n{1'b1}}, in_ready);
      for (int p = 0; p < umi_n; p++)
         check_output("parallel", umi_n - 1 - p, p);
      step_cycle();
      in_valid = '0;
   endtask

   initial
   begin
      reset_dut();
      for (int p = 0; p < umi_n; p++)
         for (int o = 0; o < umi_n; o++)
            send_and_check(p, o);
      contend_fixed();
      contend_rr();
      stall_check();
      mask_check();
      parallel_check();
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/umi_switch_top.sv
// Top level of the four-port UMI switch
// Flat per-port vectors in, port i sits at slice i of each vector
// Decoders build the request matrix that feeds the crossbar
`default_nettype none

module umi_switch_top
(
   input  wire                                          clk,
   input  wire                                          rst,
   // Incoming messages
   input  wire  [umi_pkg::umi_n-1:0]                    in_valid,
   input  wire  [umi_pkg::umi_n*umi_pkg::umi_cw-1:0]    in_cmd,
   input  wire  [umi_pkg::umi_n*umi_pkg::umi_aw-1:0]    in_dst_addr,
   input  wire  [umi_pkg::umi_n*umi_pkg::umi_aw-1:0]    in_src_addr,
   input  wire  [umi_pkg::umi_n*umi_pkg::umi_uw-1:0]    in_payload,
   output logic [umi_pkg::umi_n-1:0]                    in_ready,
   // Outgoing messages
   output logic [umi_pkg::umi_n-1:0]                    out_valid,
   output logic [umi_pkg::umi_n*umi_pkg::umi_cw-1:0]    out_cmd,
   output logic [umi_pkg::umi_n*umi_pkg::umi_aw-1:0]    out_dst_addr,
   output logic [umi_pkg::umi_n*umi_pkg::umi_aw-1:0]    out_src_addr,
   output logic [umi_pkg::umi_n*umi_pkg::umi_uw-1:0]    out_payload,
   input  wire  [umi_pkg::umi_n-1:0]                    out_ready,
   // Controls
   input  wire umi_pkg::arb_mode_e                      mode,  // 0 fixed, 1 round robin
   input  wire  [umi_pkg::umi_n*umi_pkg::umi_n-1:0]     mask   // Bit o*4+i blocks i to o
);

   import umi_pkg::*;

   umi_if in_bus  [umi_n] ();
   umi_if out_bus [umi_n] ();

   logic [umi_n-1:0]       dec_req [umi_n];  // Per-input one-hot
   logic [umi_n*umi_n-1:0] request;          // Same layout as mask

   for (genvar i = 0; i < umi_n; i++)
   begin : g_port
      // Flat slices onto the input bus
      assign in_bus[i].valid    = in_valid[i];
      assign in_bus[i].cmd      = in_cmd[i*umi_cw +: umi_cw];
      assign in_bus[i].dst_addr = in_dst_addr[i*umi_aw +: umi_aw];
      assign in_bus[i].src_addr = in_src_addr[i*umi_aw +: umi_aw];
      assign in_bus[i].payload  = in_payload[i*umi_uw +: umi_uw];
      assign in_ready[i]        = in_bus[i].ready;

      umi_decode dec_i
      (
         .clk (clk),
         .rst (rst),
         .bus (in_bus[i]),
         .req (dec_req[i])
      );

      // Transpose into output-major order
      for (genvar o = 0; o < umi_n; o++)
      begin : g_req
         assign request[o*umi_n + i] = dec_req[i][o];
      end

      // Output bus back to flat slices
      assign out_valid[i]                    = out_bus[i].valid;
      assign out_cmd[i*umi_cw +: umi_cw]      = out_bus[i].cmd;
      assign out_dst_addr[i*umi_aw +: umi_aw] = out_bus[i].dst_addr;
      assign out_src_addr[i*umi_aw +: umi_aw] = out_bus[i].src_addr;
      assign out_payload[i*umi_uw +: umi_uw]  = out_bus[i].payload;
      assign out_bus[i].ready                 = out_ready[i];
   end

   umi_crossbar xbar_i
   (
      .clk     (clk),
      .rst     (rst),
      .mode    (mode),
      .mask    (mask),
      .request (request),
      .in_bus  (in_bus),
      .out_bus (out_bus)
   );

endmodule

`default_nettype wire

//--- crossbar/umi_crossbar.sv
// Four-by-four UMI crossbar
// Request and mask bit o*umi_n+i mean input i asks for (or is barred from) output o
// One arbiter per output, field muxes steer the winner, inputs see ready only
// when every output they ask for has granted them and is itself ready
`default_nettype none

module umi_crossbar
(
   input  wire                                      clk,
   input  wire                                      rst,
   input  wire umi_pkg::arb_mode_e                  mode,     // Shared by all arbiters
   input  wire [umi_pkg::umi_n*umi_pkg::umi_n-1:0]  mask,     // Forbidden pairs
   input  wire [umi_pkg::umi_n*umi_pkg::umi_n-1:0]  request,  // From the decoders
   umi_if.sink                                      in_bus  [umi_pkg::umi_n],
   umi_if.source                                    out_bus [umi_pkg::umi_n]
);

   import umi_pkg::*;

   umi_cmd_t               in_cmd     [umi_n];
   umi_addr_t              in_dst     [umi_n];
   umi_addr_t              in_src     [umi_n];
   umi_data_t              in_payload [umi_n];
   logic [umi_n-1:0]       in_ready;
   logic [umi_n-1:0]       out_valid;
   logic [umi_n-1:0]       out_ready;
   logic [umi_n*umi_n-1:0] pair_ready;  // Per input/output pair

   // ##############################
   // Input side
   // ##############################

   for (genvar i = 0; i < umi_n; i++)
   begin : g_in
      assign in_cmd[i]       = in_bus[i].cmd;
      assign in_dst[i]       = in_bus[i].dst_addr;
      assign in_src[i]       = in_bus[i].src_addr;
      assign in_payload[i]   = in_bus[i].payload;
      assign in_bus[i].ready = in_ready[i];
   end

   // Input ready needs every one of its pairs ready
   always_comb
   begin
      in_ready = '1;
      for (int i = 0; i < umi_n; i++)
      begin
         for (int o = 0; o < umi_n; o++)
         begin
            in_ready[i] = in_ready[i] & pair_ready[o*umi_n + i];
         end
      end
   end

   // ##############################
   // Arbiters and muxes per output
   // ##############################

   for (genvar o = 0; o < umi_n; o++)
   begin : g_out
      logic [umi_n-1:0] sel;  // This output's grants

      umi_arbiter arb_i
      (
         .clk      (clk),
         .rst      (rst),
         .mode     (mode),
         .requests (request[o*umi_n +: umi_n]),
         .mask     (mask[o*umi_n +: umi_n]),
         .accept   (out_valid[o] & out_ready[o]),  // Transfer this cycle
         .grants   (sel)
      );

      assign out_valid[o]     = |sel;
      assign out_ready[o]     = out_bus[o].ready;
      assign out_bus[o].valid = out_valid[o];

      // Pair is fine if not requested, or granted with the output ready
      assign pair_ready[o*umi_n +: umi_n] = ~request[o*umi_n +: umi_n]
                                          | (sel & {umi_n{out_ready[o]}});

      umi_vmux #(.payload_t(umi_cmd_t))  cmd_mux_i (.sel(sel), .in(in_cmd), .out(out_bus[o].cmd));
      umi_vmux #(.payload_t(umi_addr_t)) dst_mux_i (.sel(sel), .in(in_dst), .out(out_bus[o].dst_addr));
      umi_vmux #(.payload_t(umi_addr_t)) src_mux_i (.sel(sel), .in(in_src), .out(out_bus[o].src_addr));
      umi_vmux #(.payload_t(umi_data_t)) pld_mux_i
      (
         .sel (sel),
         .in  (in_payload),
         .out (out_bus[o].payload)
      );
   end

endmodule

`default_nettype wire

//--- crossbar/umi_vmux.sv
// One-hot select multiplexer over the switch inputs
// ORs together every input whose sel bit is set, zero when sel is empty
// Field type comes in as a type parameter so one block serves every field
`default_nettype none

module umi_vmux
#(
   parameter type payload_t = logic
)
(
   input  wire [umi_pkg::umi_n-1:0] sel,                // One-hot grant
   input  wire payload_t            in [umi_pkg::umi_n], // One per input
   output payload_t                 out
);

   // AND-OR tree, no priority needed with one-hot sel
   always_comb
   begin
      out = '0;
      for (int i = 0; i < umi_pkg::umi_n; i++)
      begin
         if (sel[i])
         begin
            out = out | in[i];
         end
      end
   end

endmodule

`default_nettype wire

//--- crossbar/umi_arbiter.sv
// Arbiter for one crossbar output
// Fixed priority picks the lowest eligible input, round robin starts the
// search at a pointer that moves one past the winner on each transfer
// Masked inputs never win
`default_nettype none

module umi_arbiter
(
   input  wire                        clk,
   input  wire                        rst,
   input  wire umi_pkg::arb_mode_e    mode,      // Fixed or round robin
   input  wire [umi_pkg::umi_n-1:0]   requests,  // One bit per input
   input  wire [umi_pkg::umi_n-1:0]   mask,      // Set bit blocks that input
   input  wire                        accept,    // Output handshake done
   output logic [umi_pkg::umi_n-1:0]  grants     // One-hot or zero
);

   import umi_pkg::*;

   logic [umi_n-1:0]     eligible;  // Unmasked requests
   logic [umi_sel_w-1:0] ptr;       // Round-robin start point
   logic [umi_sel_w-1:0] start;     // Where the search begins
   logic [umi_sel_w-1:0] idx;       // Search position
   logic [umi_sel_w-1:0] win;       // Index of the granted input
   logic                 found;

   assign eligible = requests & ~mask;
   assign start    = (mode == arb_rr) ? ptr : '0;  // Codes 2 and 3 act fixed

   // Scan from start, wrap around, first hit wins
   always_comb
   begin
      grants = '0;
      win    = '0;
      found  = 1'b0;
      idx    = start;
      for (int k = 0; k < umi_n; k++)
      begin
         idx = start + umi_sel_w'(k);  // Wraps at umi_n
         if (!found && eligible[idx])
         begin
            grants[idx] = 1'b1;
            win         = idx;
            found       = 1'b1;
         end
      end
   end

   // Pointer moves only on a completed transfer
   always_ff @(posedge clk)
   begin
      if (rst)
         ptr <= '0;
      else if (accept)
         ptr <= win + 1'b1;  // One past the winner
   end

   // ##############################
   // Checks
   // ##############################

   a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(grants));

   // Only an unmasked requester can win
   a_grant_legal: assert property (@(posedge clk) disable iff (rst)
      (grants & ~eligible) == '0);

   // Stalled output keeps its winner while the inputs hold
   a_grant_hold: assert property (@(posedge clk) disable iff (rst)
      (|grants && !accept) ##1 ($stable(requests) && $stable(mask) && $stable(mode))
      |-> $stable(grants));

endmodule

`default_nettype wire

//--- crossbar/umi_decode.sv
// Address decoder for one switch input
// Turns the routing bits of dst_addr into a one-hot output request
// Request is all zero while the input has no valid message
`default_nettype none

module umi_decode
(
   input  wire                        clk,   // Assertion clock only
   input  wire                        rst,
   umi_if.sink                        bus,   // Input port being decoded
   output logic [umi_pkg::umi_n-1:0]  req    // One bit per output
);

   import umi_pkg::*;

   logic [umi_sel_w-1:0] route;  // Target output index

   // Top address bits name the port
   assign route = bus.dst_addr[umi_route_lsb +: umi_sel_w];

   always_comb
   begin
      req = '0;
      if (bus.valid)
      begin
         req[route] = 1'b1;  // Exactly one output per message
      end
   end

   // ##############################
   // Checks
   // ##############################

   // Valid message always asks for a single output
   a_req_onehot: assert property (@(posedge clk) disable iff (rst)
      bus.valid |-> $onehot(req));

endmodule

`default_nettype wire

//--- common/umi_if.sv
// One UMI port: valid/ready handshake plus command, addresses and payload
// Source side drives the message, sink side answers with ready
`default_nettype none

interface umi_if;

   import umi_pkg::*;

   logic      valid;     // Message present
   logic      ready;     // Sink takes it this cycle
   umi_cmd_t  cmd;       // Opcode and size bits
   umi_addr_t dst_addr;  // Top bits pick the output port
   umi_addr_t src_addr;  // Return address
   umi_data_t payload;

   // Producer of a message
   modport source
   (
      output valid,
      output cmd,
      output dst_addr,
      output src_addr,
      output payload,
      input  ready
   );

   // Consumer of a message
   modport sink
   (
      input  valid,
      input  cmd,
      input  dst_addr,
      input  src_addr,
      input  payload,
      output ready
   );

endinterface

`default_nettype wire

//--- common/umi_pkg.sv
// Shared constants and types for the four-port UMI message switch
// Imported by the port interface, the decoders, the arbiters and the crossbar
`default_nettype none

package umi_pkg;

   // ##############################
   // Port and field sizes
   // ##############################

   localparam int umi_n     = 4;              // Ports on each side
   localparam int umi_cw    = 32;             // Command width
   localparam int umi_aw    = 16;             // Address width
   localparam int umi_uw    = 64;             // Payload width
   localparam int umi_sel_w = $clog2(umi_n);  // Output index width

   // Routing field sits in the top address bits
   localparam int umi_route_lsb = umi_aw - umi_sel_w;

   // ##############################
   // Field types
   // ##############################

   typedef logic [umi_cw-1:0] umi_cmd_t;
   typedef logic [umi_aw-1:0] umi_addr_t;
   typedef logic [umi_uw-1:0] umi_data_t;

   // Arbiter mode, codes 2 and 3 fall back to fixed priority
   typedef enum logic [1:0]
   {
      arb_fixed = 2'd0,  // Lowest index wins
      arb_rr    = 2'd1   // Rotating pointer
   } arb_mode_e;

endpackage

`default_nettype wire
